/* logic/lsu_defs.svh */
// Sizes fit RV32 with four byte lanes and need a power-of-two queue depth
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address width of the hart
`define LSU_XLEN 32

// Byte lanes in one memory word
`define LSU_BYTES 4

// Memory credits held by the issue stage after reset
`define LSU_BUS_CREDITS 4

// Entries in the in-order pending queue
`define LSU_QUEUE_DEPTH 8

// Queue tag for stores and sc.w whose response carries no load data
// No RV32 load uses this funct3 code
`define LSU_FUNCT3_NODATA 3'b111

`endif

/* logic/lsuPkg.sv */
// Encodings cover plain loads and stores plus LR/SC only as there is no AMO support
package lsuPkg;

  // Operation requested by the CPU
  typedef enum logic [1:0] {
    opLoad             = 2'b00,
    opStore            = 2'b01,
    opLoadReserved     = 2'b10,
    opStoreConditional = 2'b11
  } memOp;

  // Fault reported with a response
  // Only misalignment is checked here
  typedef enum logic [1:0] {
    faultNone            = 2'b00,
    faultLoadMisaligned  = 2'b01,
    faultStoreMisaligned = 2'b10
  } lsuFault;

endpackage

/* logic/accessCheck.sv */
// First stage holds one operation and a single word reservation with no timeout or snooping
`timescale 1ns/1ps
`include "lsu_defs.svh"

module accessCheck (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reqValid,
  input  lsuPkg::memOp           reqOp,
  input  logic [2:0]             reqFunct3,
  input  logic [`LSU_XLEN-1:0]   reqAddr,
  input  logic [`LSU_XLEN-1:0]   reqWriteData,
  input  logic                   stageAdvance,
  output logic                   reqReady,
  output logic                   stageValid,
  output lsuPkg::memOp           stageOp,
  output logic [2:0]             stageFunct3,
  output logic [1:0]             stageOffset,
  output logic [`LSU_XLEN-1:2]   stageWordAddr,
  output logic [`LSU_BYTES-1:0]  stageByteEn,
  output logic [`LSU_XLEN-1:0]   stageWriteData,
  output lsuPkg::lsuFault        stageFault,
  output logic                   stageLocal
);
  import lsuPkg::*;

  logic                  take;
  logic                  misaligned;
  logic                  isLoad;
  logic                  resValid;
  logic [`LSU_XLEN-1:2]  resWordAddr;
  logic                  resHit;
  logic                  scFail;
  logic [`LSU_BYTES-1:0] byteEn;
  logic [`LSU_XLEN-1:0]  laneData;
  lsuFault               fault;

  // Register frees up when empty or when its operation moves on this cycle
  assign reqReady = !stageValid || stageAdvance;
  assign take     = reqValid && reqReady;

  assign isLoad = (reqOp == opLoad) || (reqOp == opLoadReserved);

  // Reservation match on the word address
  assign resHit = resValid && (reqAddr[`LSU_XLEN-1:2] == resWordAddr);
  assign scFail = (reqOp == opStoreConditional) && !resHit;

  ////////////////////////////////////////////////////////////////////////////
  // Alignment and lane placement
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (reqFunct3[1:0])
      // Byte access
      2'b00: begin
        misaligned = 1'b0;
        byteEn     = {{(`LSU_BYTES-1){1'b0}}, 1'b1} << reqAddr[1:0];
        laneData   = {4{reqWriteData[7:0]}};
      end
      // Halfword needs an even address
      2'b01: begin
        misaligned = reqAddr[0];
        byteEn     = {{(`LSU_BYTES-2){1'b0}}, 2'b11} << reqAddr[1:0];
        laneData   = {2{reqWriteData[15:0]}};
      end
      // Word needs both low bits clear
      2'b10: begin
        misaligned = |reqAddr[1:0];
        byteEn     = '1;
        laneData   = reqWriteData;
      end
      // Doubleword has no place on RV32 so always faults
      default: begin
        misaligned = 1'b1;
        byteEn     = '1;
        laneData   = reqWriteData;
      end
    endcase
    if (!misaligned) begin
      fault = faultNone;
    end else if (isLoad) begin
      fault = faultLoadMisaligned;
    end else begin
      fault = faultStoreMisaligned;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register and reservation
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      stageValid <= 1'b0;
    end else if (take) begin
      stageValid <= 1'b1;
    end else if (stageAdvance) begin
      stageValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      stageOp        <= reqOp;
      stageFunct3    <= reqFunct3;
      stageOffset    <= reqAddr[1:0];
      stageWordAddr  <= reqAddr[`LSU_XLEN-1:2];
      stageByteEn    <= byteEn;
      stageWriteData <= laneData;
      stageFault     <= fault;
      // Faults and failed sc.w never reach memory
      stageLocal     <= misaligned || scFail;
    end
  end

  // Any sc.w drops the reservation, as does a store hitting the reserved word
  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else if (take) begin
      if ((reqOp == opLoadReserved) && !misaligned) begin
        resValid <= 1'b1;
      end else if ((reqOp == opStoreConditional) ||
                   ((reqOp == opStore) && !misaligned && resHit)) begin
        resValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && (reqOp == opLoadReserved) && !misaligned) begin
      resWordAddr <= reqAddr[`LSU_XLEN-1:2];
    end
  end

endmodule

/* logic/busIssue.sv */
// Issue stage expects the memory to return exactly one credit per request it was sent
`timescale 1ns/1ps
`include "lsu_defs.svh"

module busIssue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stageValid,
  input  lsuPkg::memOp           stageOp,
  input  logic [2:0]             stageFunct3,
  input  logic [1:0]             stageOffset,
  input  logic [`LSU_XLEN-1:2]   stageWordAddr,
  input  logic [`LSU_BYTES-1:0]  stageByteEn,
  input  logic [`LSU_XLEN-1:0]   stageWriteData,
  input  lsuPkg::lsuFault        stageFault,
  input  logic                   stageLocal,
  input  logic                   queueFull,
  input  logic                   memCreditReturn,
  output logic                   stageAdvance,
  output logic                   memReq,
  output logic                   memWrite,
  output logic [`LSU_XLEN-1:0]   memAddr,
  output logic [`LSU_BYTES-1:0]  memByteEn,
  output logic [`LSU_XLEN-1:0]   memWriteData,
  output logic                   enqValid,
  output logic [2:0]             enqFunct3,
  output logic [1:0]             enqOffset,
  output logic                   enqLocal,
  output lsuPkg::lsuFault        enqFault,
  output logic                   enqScFail
);
  import lsuPkg::*;

  localparam int CreditBits = $clog2(`LSU_BUS_CREDITS + 1);

  logic [CreditBits-1:0] creditCount;
  logic                  hasCredit;
  logic                  isLoad;

  assign hasCredit = (creditCount != '0);
  assign isLoad    = (stageOp == opLoad) || (stageOp == opLoadReserved);

  // Move on only with queue room
  // Local entries skip memory so they need no credit
  assign stageAdvance = stageValid && !queueFull && (stageLocal || hasCredit);

  ////////////////////////////////////////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////////////////////////////////////////

  assign memReq       = stageAdvance && !stageLocal;
  assign memWrite     = memReq && !isLoad;
  assign memAddr      = {stageWordAddr, 2'b00};
  assign memByteEn    = stageByteEn;
  assign memWriteData = stageWriteData;

  // Return and issue in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      creditCount <= CreditBits'(`LSU_BUS_CREDITS);
    end else begin
      creditCount <= creditCount + CreditBits'(memCreditReturn) - CreditBits'(memReq);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending queue entry
  ////////////////////////////////////////////////////////////////////////////

  assign enqValid  = stageAdvance;
  // Stores and sc.w carry the no-data tag so their response is zero
  assign enqFunct3 = isLoad ? stageFunct3 : `LSU_FUNCT3_NODATA;
  assign enqOffset = stageOffset;
  assign enqLocal  = stageLocal;
  assign enqFault  = stageFault;
  // A local sc.w without a fault lost its reservation
  assign enqScFail = (stageOp == opStoreConditional) && stageLocal && (stageFault == faultNone);

endmodule

/* logic/loadAlign.sv */
// Memory data must come back in request order and the CPU takes every response at once
`timescale 1ns/1ps
`include "lsu_defs.svh"

module loadAlign (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enqValid,
  input  logic [2:0]           enqFunct3,
  input  logic [1:0]           enqOffset,
  input  logic                 enqLocal,
  input  lsuPkg::lsuFault      enqFault,
  input  logic                 enqScFail,
  input  logic                 memRspValid,
  input  logic [`LSU_XLEN-1:0] memRspData,
  output logic                 queueFull,
  output logic                 rspValid,
  output logic [`LSU_XLEN-1:0] rspData,
  output lsuPkg::lsuFault      rspFault
);
  import lsuPkg::*;

  localparam int PtrBits = $clog2(`LSU_QUEUE_DEPTH);

  // Pending entries in program order
  logic [2:0]           qFunct3 [`LSU_QUEUE_DEPTH];
  logic [1:0]           qOffset [`LSU_QUEUE_DEPTH];
  logic                 qLocal  [`LSU_QUEUE_DEPTH];
  lsuFault              qFault  [`LSU_QUEUE_DEPTH];
  logic                 qScFail [`LSU_QUEUE_DEPTH];
  logic [PtrBits-1:0]   headPtr;
  logic [PtrBits-1:0]   tailPtr;
  logic [PtrBits:0]     count;

  // Memory words that arrive while a local entry still holds the head
  logic [`LSU_XLEN-1:0] dataBuf [`LSU_QUEUE_DEPTH];
  logic [PtrBits-1:0]   bufRd;
  logic [PtrBits-1:0]   bufWr;
  logic [PtrBits:0]     bufCount;

  logic                 headValid;
  logic                 headMem;
  logic                 headDone;
  logic                 bufPush;
  logic                 bufPop;
  logic [`LSU_XLEN-1:0] headWord;
  logic [`LSU_XLEN-1:0] laneWord;
  logic [`LSU_XLEN-1:0] loadValue;
  logic [`LSU_XLEN-1:0] respValue;

  assign queueFull = (count == (PtrBits+1)'(`LSU_QUEUE_DEPTH));
  assign headValid = (count != '0);
  assign headMem   = headValid && !qLocal[headPtr];

  // Head finishes when local, or when its memory word is buffered or arriving
  assign headDone = headValid && (qLocal[headPtr] || (bufCount != '0) || memRspValid);
  assign bufPop   = headMem && (bufCount != '0);
  // Bypass the buffer when the head is waiting on this very word
  assign bufPush  = memRspValid && !(headMem && (bufCount == '0));
  assign headWord = (bufCount != '0) ? dataBuf[bufRd] : memRspData;

  ////////////////////////////////////////////////////////////////////////////
  // Lane select and extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    laneWord = headWord >> {qOffset[headPtr], 3'b000};
    case (qFunct3[headPtr])
      3'b000:  loadValue = {{(`LSU_XLEN-8){laneWord[7]}}, laneWord[7:0]};
      3'b001:  loadValue = {{(`LSU_XLEN-16){laneWord[15]}}, laneWord[15:0]};
      3'b010:  loadValue = laneWord;
      3'b100:  loadValue = {{(`LSU_XLEN-8){1'b0}}, laneWord[7:0]};
      3'b101:  loadValue = {{(`LSU_XLEN-16){1'b0}}, laneWord[15:0]};
      // Stores and sc.w land here
      default: loadValue = '0;
    endcase
    // Faults give zero, a failed sc.w gives one
    if (qLocal[headPtr]) begin
      respValue = {{(`LSU_XLEN-1){1'b0}}, qScFail[headPtr]};
    end else begin
      respValue = loadValue;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Queue and buffer state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr  <= '0;
      tailPtr  <= '0;
      count    <= '0;
      bufRd    <= '0;
      bufWr    <= '0;
      bufCount <= '0;
      rspValid <= 1'b0;
    end else begin
      rspValid <= headDone;
      if (enqValid) tailPtr <= tailPtr + 1'b1;
      if (headDone) headPtr <= headPtr + 1'b1;
      if (enqValid && !headDone) begin
        count <= count + 1'b1;
      end else if (!enqValid && headDone) begin
        count <= count - 1'b1;
      end
      if (bufPush) bufWr <= bufWr + 1'b1;
      if (bufPop) bufRd <= bufRd + 1'b1;
      if (bufPush && !bufPop) begin
        bufCount <= bufCount + 1'b1;
      end else if (!bufPush && bufPop) begin
        bufCount <= bufCount - 1'b1;
      end
    end
  end

  // Entry and data storage
  always_ff @(posedge clk) begin
    if (enqValid) begin
      qFunct3[tailPtr] <= enqFunct3;
      qOffset[tailPtr] <= enqOffset;
      qLocal[tailPtr]  <= enqLocal;
      qFault[tailPtr]  <= enqFault;
      qScFail[tailPtr] <= enqScFail;
    end
    if (bufPush) dataBuf[bufWr] <= memRspData;
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (headDone) begin
      rspData  <= respValue;
      rspFault <= qFault[headPtr];
    end
  end

endmodule

/* logic/lsuTop.sv */
// RV32 load/store unit with no cache or translation whose responses are always accepted
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsuTop (
  input  logic                   clk,
  input  logic                   reset,
  // CPU request
  input  logic                   reqValid,
  input  lsuPkg::memOp           reqOp,
  input  logic [2:0]             reqFunct3,
  input  logic [`LSU_XLEN-1:0]   reqAddr,
  input  logic [`LSU_XLEN-1:0]   reqWriteData,
  output logic                   reqReady,
  // CPU response
  output logic                   rspValid,
  output logic [`LSU_XLEN-1:0]   rspData,
  output lsuPkg::lsuFault        rspFault,
  // Memory port
  output logic                   memReq,
  output logic                   memWrite,
  output logic [`LSU_XLEN-1:0]   memAddr,
  output logic [`LSU_BYTES-1:0]  memByteEn,
  output logic [`LSU_XLEN-1:0]   memWriteData,
  input  logic                   memCreditReturn,
  input  logic                   memRspValid,
  input  logic [`LSU_XLEN-1:0]   memRspData
);
  import lsuPkg::*;

  // Stage one to stage two
  logic                  stageValid;
  memOp                  stageOp;
  logic [2:0]            stageFunct3;
  logic [1:0]            stageOffset;
  logic [`LSU_XLEN-1:2]  stageWordAddr;
  logic [`LSU_BYTES-1:0] stageByteEn;
  logic [`LSU_XLEN-1:0]  stageWriteData;
  lsuFault               stageFault;
  logic                  stageLocal;
  logic                  stageAdvance;

  // Stage two to stage three
  logic                  enqValid;
  logic [2:0]            enqFunct3;
  logic [1:0]            enqOffset;
  logic                  enqLocal;
  lsuFault               enqFault;
  logic                  enqScFail;
  logic                  queueFull;

  // Alignment, lanes and reservation
  accessCheck accessStage (.*);

  // Credits and memory requests
  busIssue issueStage (.*);

  // In-order completion and load extraction
  loadAlign alignStage (.*);

endmodule

/* testbench/tbClock.sv */
// Free-running clock that starts low with a 20 ns period and no enable
`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  // Half period of 10 ns gives the 20 ns cycle
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

endmodule

/* testbench/memResponder.sv */
// Models 64 words below address 0x100 that start at zero and answers every request in order
`timescale 1ns/1ps
`include "lsu_defs.svh"

module memResponder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   memReq,
  input  logic                   memWrite,
  input  logic [`LSU_XLEN-1:0]   memAddr,
  input  logic [`LSU_BYTES-1:0]  memByteEn,
  input  logic [`LSU_XLEN-1:0]   memWriteData,
  output logic                   memCreditReturn,
  output logic                   memRspValid,
  output logic [`LSU_XLEN-1:0]   memRspData
);

  localparam int Words = 64;

  logic [`LSU_XLEN-1:0]  mem [Words];
  // Responses waiting for their cycle, oldest first
  logic [`LSU_XLEN-1:0]  pendData [$];
  int                    pendDue [$];
  int                    seed;
  int                    cycle;
  int                    lastDue;
  int                    due;
  logic                  takeReq;
  logic                  takeWrite;
  logic [5:0]            takeIdx;
  logic [`LSU_BYTES-1:0] takeEn;
  logic [`LSU_XLEN-1:0]  takeData;

  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = '0;
    end
    seed            = 49;
    cycle           = 0;
    lastDue         = 0;
    memCreditReturn = 1'b0;
    memRspValid     = 1'b0;
    memRspData      = '0;
    forever begin
      // Request lines are settled in the middle of the cycle
      @(negedge clk);
      takeReq   = memReq;
      takeWrite = memWrite;
      takeIdx   = memAddr[7:2];
      takeEn    = memByteEn;
      takeData  = memWriteData;
      @(posedge clk);
      #1;
      cycle++;
      memRspValid     = 1'b0;
      memCreditReturn = 1'b0;
      if (reset) begin
        pendData.delete();
        pendDue.delete();
      end else begin
        if (takeReq) begin
          // Access happens in issue order so later loads see earlier stores
          if (takeWrite) begin
            for (int b = 0; b < `LSU_BYTES; b++) begin
              if (takeEn[b]) begin
                mem[takeIdx][b*8 +: 8] = takeData[b*8 +: 8];
              end
            end
          end
          // Latency of 1 to 4 cycles that never overtakes an older response
          due = cycle + ($random(seed) & 3);
          if (due <= lastDue) begin
            due = lastDue + 1;
          end
          lastDue = due;
          pendData.push_back(mem[takeIdx]);
          pendDue.push_back(due);
        end
        // At most one response per cycle and its credit comes back with it
        if ((pendDue.size() != 0) && (pendDue[0] <= cycle)) begin
          memRspData      = pendData.pop_front();
          void'(pendDue.pop_front());
          memRspValid     = 1'b1;
          memCreditReturn = 1'b1;
        end
      end
    end
  end

endmodule

/* testbench/lsu_properties.sv */
// Checks apply outside reset only and rely on the issue stage counter named creditCount
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsuProperties (
  input logic                                     clk,
  input logic                                     reset,
  input logic                                     memReq,
  input logic                                     memCreditReturn,
  input logic [$clog2(`LSU_BUS_CREDITS + 1)-1:0]  creditCount,
  input logic                                     enqValid,
  input logic                                     queueFull
);

  // Requests sent minus credits returned, counted apart from the issue stage
  int outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(memReq) - int'(memCreditReturn);
    end
  end

  // Memory port never runs ahead of its credits
  noRequestWithoutCredit: assert property (
    @(posedge clk) disable iff (reset) memReq |-> (outstanding < `LSU_BUS_CREDITS))
    else $error("memReq raised while no credit was left");

  creditWithinLimit: assert property (
    @(posedge clk) disable iff (reset) int'(creditCount) <= `LSU_BUS_CREDITS)
    else $error("credit count rose above its initial value");

  // Pending queue never takes an entry it has no room for
  noEnqueueWhenFull: assert property (
    @(posedge clk) disable iff (reset) queueFull |-> !enqValid)
    else $error("enqValid raised while the pending queue was full");

endmodule

bind busIssue lsuProperties issueChecks (
  .clk, .reset, .memReq, .memCreditReturn, .creditCount, .enqValid, .queueFull
);

/* testbench/lsuTb.sv */
// Runs from the project root, reads testbench/lsu_tests.txt and handles at most 64 vectors
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsuTb;
  import lsuPkg::*;

  localparam int MaxTests = 64;
  localparam int Fields   = 6;

  logic                  clk;
  logic                  reset;
  logic                  reqValid;
  memOp                  reqOp;
  logic [2:0]            reqFunct3;
  logic [`LSU_XLEN-1:0]  reqAddr;
  logic [`LSU_XLEN-1:0]  reqWriteData;
  logic                  reqReady;
  logic                  rspValid;
  logic [`LSU_XLEN-1:0]  rspData;
  lsuFault               rspFault;
  logic                  memReq;
  logic                  memWrite;
  logic [`LSU_XLEN-1:0]  memAddr;
  logic [`LSU_BYTES-1:0] memByteEn;
  logic [`LSU_XLEN-1:0]  memWriteData;
  logic                  memCreditReturn;
  logic                  memRspValid;
  logic [`LSU_XLEN-1:0]  memRspData;

  // Six hex fields per test and an op field of ff ends the list
  logic [`LSU_XLEN-1:0]  vectors [MaxTests * Fields];
  logic [`LSU_XLEN-1:0]  expData [$];
  lsuFault               expFault [$];
  int                    numTests;
  int                    responses = 0;
  int                    dataErrors = 0;
  int                    faultErrors = 0;
  int                    extraResponses = 0;
  int                    cycleCount = 0;
  int                    cycleLimit = 0;

  tbClock clockGen (.clk(clk));
  memResponder memModel (.*);
  lsuTop dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Request driving and response checking
  ////////////////////////////////////////////////////////////////////////////

  // Holds one request until an edge sees it with reqReady high
  task automatic sendRequest(input int idx);
    int   base;
    logic accepted;
    base         = idx * Fields;
    reqValid     = 1'b1;
    reqOp        = memOp'(vectors[base][1:0]);
    reqFunct3    = vectors[base + 1][2:0];
    reqAddr      = vectors[base + 2];
    reqWriteData = vectors[base + 3];
    expData.push_back(vectors[base + 4]);
    expFault.push_back(lsuFault'(vectors[base + 5][1:0]));
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = reqReady;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic checkResponse;
    logic [`LSU_XLEN-1:0] wantData;
    lsuFault              wantFault;
    assert (expData.size() != 0) else begin
      extraResponses++;
      $display("A response arrived at %0t ns with no request outstanding", $time);
    end
    if (expData.size() != 0) begin
      wantData  = expData.pop_front();
      wantFault = expFault.pop_front();
      assert (rspData == wantData) else begin
        dataErrors++;
        $display("ERR %0t ns: response %0d data %h, expected %h",
                 $time, responses, rspData, wantData);
      end
      assert (rspFault == wantFault) else begin
        faultErrors++;
        $display("ERR %0t ns: response %0d fault %0d, expected %0d",
                 $time, responses, rspFault, wantFault);
      end
      responses++;
    end
  endtask

  // Registered response is stable in the middle of the cycle
  always @(negedge clk) begin
    if (!reset && rspValid) begin
      checkResponse();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    reqValid     = 1'b0;
    reqOp        = opLoad;
    reqFunct3    = 3'b000;
    reqAddr      = '0;
    reqWriteData = '0;
    $readmemh("testbench/lsu_tests.txt", vectors);
    numTests = 0;
    while ((numTests < MaxTests) && (vectors[numTests * Fields] != 32'hff)) begin
      numTests++;
    end
    cycleLimit = numTests * 20 + 200;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    // Back to back while the LSU keeps up
    for (int i = 0; i < numTests; i++) begin
      sendRequest(i);
    end
    reqValid = 1'b0;
    wait (responses == numTests);
    // Room for any stray response to show up
    repeat (4) @(posedge clk);
    if (numTests == 0) begin
      $display("No test vectors were read from the data file");
    end
    $display("Errors: data %0d, fault %0d, unexpected responses %0d, responses %0d of %0d",
             dataErrors, faultErrors, extraResponses, responses, numTests);
    if ((numTests > 0) && (dataErrors + faultErrors + extraResponses == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Limit grows with the number of vectors
  initial begin : watchdog
    wait (cycleLimit != 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles with %0d of %0d responses and %0d errors",
             cycleCount, responses, numTests, dataErrors + faultErrors + extraResponses);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* testbench/lsu_tests.txt */
// Hex columns: op funct3 address writeData expectedData expectedFault
// op 0 load, 1 store, 2 lr.w, 3 sc.w; fault 0 none, 1 load misaligned, 2 store misaligned
// Word, half and byte stores merge into one word
1 2 00000010 11223344 00000000 0
1 1 00000012 0000aabb 00000000 0
1 0 00000011 000000cc 00000000 0
0 2 00000010 00000000 aabbcc44 0
// Sign and zero extension by lane
0 0 00000013 00000000 ffffffaa 0
0 4 00000013 00000000 000000aa 0
0 1 00000012 00000000 ffffaabb 0
0 5 00000012 00000000 0000aabb 0
0 0 00000010 00000000 00000044 0
0 1 00000010 00000000 ffffcc44 0
// Misaligned accesses fault and leave memory alone
0 1 00000011 00000000 00000000 1
0 2 00000012 00000000 00000000 1
1 1 00000013 00005555 00000000 2
1 2 00000011 66666666 00000000 2
0 2 00000010 00000000 aabbcc44 0
// Reservation success, repeat failure and address mismatch
2 2 00000020 00000000 00000000 0
3 2 00000020 12345678 00000000 0
0 2 00000020 00000000 12345678 0
3 2 00000020 00009999 00000001 0
2 2 00000020 00000000 12345678 0
3 2 00000024 00000077 00000001 0
0 2 00000024 00000000 00000000 0
0 2 00000020 00000000 12345678 0
// Burst of loads past the credit count
1 2 00000030 deadbeef 00000000 0
1 2 00000034 01020304 00000000 0
0 2 00000030 00000000 deadbeef 0
0 4 00000031 00000000 000000be 0
0 0 00000033 00000000 ffffffde 0
0 5 00000036 00000000 00000102 0
0 1 00000032 00000000 ffffdead 0
0 2 00000034 00000000 01020304 0
0 0 00000030 00000000 ffffffef 0
0 2 00000010 00000000 aabbcc44 0
// End of list
ff 0 0 0 0 0

/* files.f */
+incdir+logic
logic/lsuPkg.sv
logic/accessCheck.sv
logic/busIssue.sv
logic/loadAlign.sv
logic/lsuTop.sv
testbench/tbClock.sv
testbench/memResponder.sv
testbench/lsu_properties.sv
testbench/lsuTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = lsuTb
FILELIST  = files.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
